// File: dv/uart_properties.sv
`timescale 1ns/100ps

module uart_properties (
  input logic clock,
  input logic reset,
  input logic uart_valid,
  input logic uart_ready,
  input logic uart_tx
);

  // Read by the testbench at the end of the run
  int failures = 0;

  // One completion gives exactly one ready cycle
  ready_single_cycle: assert property (
    @(posedge clock) disable iff (reset) uart_ready |=> !uart_ready
  ) else begin
    $error("uart_ready stayed high for two cycles in a row");
    failures = failures + 1;
  end

  ready_needs_valid: assert property (
    @(posedge clock) disable iff (reset) uart_ready |-> uart_valid
  ) else begin
    $error("uart_ready came while uart_valid was low");
    failures = failures + 1;
  end

  // Line idles high once reset has been seen
  tx_idle_after_reset: assert property (
    @(posedge clock) reset |=> uart_tx
  ) else begin
    $error("uart_tx not high in the cycle after reset");
    failures = failures + 1;
  end

endmodule

bind uart uart_properties uart_checks (
  .clock(clock),
  .reset(reset),
  .uart_valid(uart_valid),
  .uart_ready(uart_ready),
  .uart_tx(uart_tx)
);

// File: dv/uart_tb.sv
`timescale 1ns/100ps

module uart_tb;

  localparam int clock_period = 100;
  localparam int drive_delay = 10;
  localparam int reset_cycles = 10;
  localparam int num_tests = 11;
  localparam int bit_cycles = uart_pkg::cycles_per_bit;
  localparam int ready_limit = 25 * bit_cycles;
  localparam int watchdog_ns = (num_tests * 25 * bit_cycles + reset_cycles) * clock_period;

  typedef enum {
    kind_write,
    kind_read,
    kind_read_bad_stop,
    kind_read_glitch,
    kind_read_stale
  } test_kind_t;

  typedef struct {
    string name;
    test_kind_t kind;
    uart_pkg::uart_byte_t data;
    uart_pkg::byte_strobe_t wstrb;
    uart_pkg::bus_word_t wdata;
    uart_pkg::bus_word_t rdata;
  } test_entry_t;

  logic clock;
  logic reset;
  logic uart_valid;
  uart_pkg::byte_strobe_t uart_wstrb;
  uart_pkg::bus_word_t uart_wdata;
  uart_pkg::bus_word_t uart_rdata;
  logic uart_ready;
  logic uart_rx;
  logic uart_tx;

  test_entry_t tests [num_tests];
  int table_size;
  int seed;
  uart_pkg::bus_word_t last_read;
  string test_name;

  uart UUT (
    .clock(clock),
    .reset(reset),
    .uart_valid(uart_valid),
    .uart_wstrb(uart_wstrb),
    .uart_wdata(uart_wdata),
    .uart_rdata(uart_rdata),
    .uart_ready(uart_ready),
    .uart_rx(uart_rx),
    .uart_tx(uart_tx)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(clock_period / 2) clock = ~clock;
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  initial begin
    #(watchdog_ns);
    fail_run("watchdog expired before all tests finished");
  end

  task automatic check_byte(input string what, input uart_pkg::uart_byte_t expected,
                            input uart_pkg::uart_byte_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("error: %s %s expected %h actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic check_word(input string what, input uart_pkg::bus_word_t expected,
                            input uart_pkg::bus_word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("error: %s %s expected %h actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic check_level(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("error: %s %s expected %b actual %b",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("error: %s %s expected %0d actual %0d",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic add_entry(input string name, input test_kind_t kind,
                           input uart_pkg::uart_byte_t data,
                           input uart_pkg::byte_strobe_t wstrb);
    test_entry_t entry;
    uart_pkg::bus_word_t noise;
    noise = $random(seed);
    entry.name = name;
    entry.kind = kind;
    entry.data = data;
    entry.wstrb = wstrb;
    // Upper bytes carry junk that must never reach the line
    entry.wdata = {noise[31:8], data};
    if (kind == kind_write) begin
      entry.rdata = last_read;
    end else begin
      entry.rdata = {24'h0, data};
      last_read = entry.rdata;
    end
    tests[table_size] = entry;
    table_size++;
  endtask

  task automatic build_table();
    uart_pkg::bus_word_t random_word;
    last_read = '0;
    table_size = 0;
    add_entry("write_basic", kind_write, 8'h55, 4'b0001);
    add_entry("write_msb", kind_write, 8'h80, 4'b0001);
    add_entry("write_upper_strobe", kind_write, 8'ha3, 4'b1000);
    add_entry("read_basic", kind_read, 8'h3c, 4'b0000);
    add_entry("read_bad_stop", kind_read_bad_stop, 8'hc5, 4'b0000);
    add_entry("read_stale", kind_read_stale, 8'h96, 4'b0000);
    add_entry("read_glitch", kind_read_glitch, 8'h71, 4'b0000);
    random_word = $random(seed);
    add_entry("write_random_0", kind_write, random_word[7:0], 4'b0011);
    random_word = $random(seed);
    add_entry("read_random_0", kind_read, random_word[7:0], 4'b0000);
    random_word = $random(seed);
    add_entry("write_random_1", kind_write, random_word[7:0], 4'b1111);
    random_word = $random(seed);
    add_entry("read_random_1", kind_read, random_word[7:0], 4'b0000);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #(drive_delay);
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) next_cycle();
  endtask

  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic stop_level);
    int i;
    uart_rx = 1'b0;
    wait_cycles(bit_cycles);
    for (i = 0; i < uart_pkg::data_bits; i++) begin
      uart_rx = data[i];
      wait_cycles(bit_cycles);
    end
    uart_rx = stop_level;
    wait_cycles(bit_cycles);
    uart_rx = 1'b1;
  endtask

  // Low for well under half a bit
  task automatic send_glitch();
    uart_rx = 1'b0;
    wait_cycles(uart_pkg::half_bit / 2 - 1);
    uart_rx = 1'b1;
  endtask

  task automatic wait_ready(output uart_pkg::bus_word_t rdata);
    int waited;
    waited = 0;
    while (uart_ready !== 1'b1) begin
      if (waited >= ready_limit) begin
        fail_run($sformatf("%s: uart_ready never came", test_name));
      end
      next_cycle();
      waited++;
    end
    rdata = uart_rdata;
    // Master samples ready on the next edge, then drops the request
    next_cycle();
    uart_valid = 1'b0;
    uart_wstrb = '0;
  endtask

  task automatic run_write(input test_entry_t entry);
    int i;
    time accept_time;
    int latency;
    uart_pkg::uart_byte_t frame;
    uart_pkg::bus_word_t rdata;
    uart_wstrb = entry.wstrb;
    uart_wdata = entry.wdata;
    uart_valid = 1'b1;
    // The bus is idle here so the next edge accepts the write
    next_cycle();
    accept_time = $time - drive_delay;
    check_level("start bit onset", 1'b0, uart_tx);
    wait_cycles(uart_pkg::half_bit);
    check_level("start bit", 1'b0, uart_tx);
    for (i = 0; i < uart_pkg::data_bits; i++) begin
      wait_cycles(bit_cycles);
      frame[i] = uart_tx;
    end
    wait_cycles(bit_cycles);
    check_level("stop bit", 1'b1, uart_tx);
    wait_ready(rdata);
    latency = int'(($time - drive_delay - accept_time) / clock_period);
    check_byte("sent byte", entry.data, frame);
    check_count("ready latency", 10 * bit_cycles + 1, latency);
    check_word("rdata", entry.rdata, rdata);
    wait_cycles(4);
  endtask

  task automatic run_read(input test_entry_t entry);
    uart_pkg::bus_word_t rdata;
    if (entry.kind == kind_read_stale) begin
      // Nobody waits for this byte
      send_frame(~entry.data, 1'b1);
      wait_cycles(2 * bit_cycles);
    end
    uart_wstrb = '0;
    uart_wdata = entry.wdata;
    uart_valid = 1'b1;
    wait_cycles(4);
    fork
      begin
        if (entry.kind == kind_read_bad_stop) begin
          send_frame(~entry.data, 1'b0);
          wait_cycles(2 * bit_cycles);
        end else if (entry.kind == kind_read_glitch) begin
          send_glitch();
          wait_cycles(bit_cycles);
        end
        send_frame(entry.data, 1'b1);
      end
      wait_ready(rdata);
    join
    check_word("rdata", entry.rdata, rdata);
    check_word("rdata held", entry.rdata, uart_rdata);
    wait_cycles(bit_cycles);
  endtask

  initial begin
    int idx;
    reset = 1'b1;
    uart_valid = 1'b0;
    uart_wstrb = '0;
    uart_wdata = '0;
    uart_rx = 1'b1;
    seed = 54608;
    test_name = "reset";
    build_table();
    wait_cycles(reset_cycles);
    reset = 1'b0;
    wait_cycles(2);
    check_level("uart_tx idle", 1'b1, uart_tx);
    check_level("uart_ready", 1'b0, uart_ready);
    check_word("rdata", '0, uart_rdata);
    for (idx = 0; idx < table_size; idx++) begin
      test_name = tests[idx].name;
      if (tests[idx].kind == kind_write) begin
        run_write(tests[idx]);
      end else begin
        run_read(tests[idx]);
      end
    end
    if (UUT.uart_checks.failures == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("a concurrent assertion failed during the run");
    end
  end

endmodule

// File: logic/uart.sv
`timescale 1ns/100ps

module uart (
  input logic clock,
  input logic reset,
  input logic uart_valid,
  input uart_pkg::byte_strobe_t uart_wstrb,
  input uart_pkg::bus_word_t uart_wdata,
  output uart_pkg::bus_word_t uart_rdata,
  output logic uart_ready,
  input logic uart_rx,
  output logic uart_tx
);

  uart_pkg::tx_request_t tx_request;
  uart_pkg::rx_frame_t rx_frame;
  logic tx_done;

  uart_bus_port bus_port (
    .clock(clock),
    .reset(reset),
    .uart_valid(uart_valid),
    .uart_wstrb(uart_wstrb),
    .uart_wdata(uart_wdata),
    .uart_rdata(uart_rdata),
    .uart_ready(uart_ready),
    .tx_request(tx_request),
    .tx_done(tx_done),
    .rx_frame(rx_frame)
  );

  uart_transmitter transmitter (
    .clock(clock),
    .reset(reset),
    .tx_request(tx_request),
    .uart_tx(uart_tx),
    .tx_done(tx_done)
  );

  // Receiver runs freely, the bus port decides which frame answers a read
  uart_receiver receiver (
    .clock(clock),
    .reset(reset),
    .uart_rx(uart_rx),
    .rx_frame(rx_frame)
  );

endmodule

// File: logic/uart_bus_port.sv
`timescale 1ns/100ps

module uart_bus_port (
  input logic clock,
  input logic reset,
  input logic uart_valid,
  input uart_pkg::byte_strobe_t uart_wstrb,
  input uart_pkg::bus_word_t uart_wdata,
  output uart_pkg::bus_word_t uart_rdata,
  output logic uart_ready,
  output uart_pkg::tx_request_t tx_request,
  input logic tx_done,
  input uart_pkg::rx_frame_t rx_frame
);

  logic write_active;
  logic read_pending;
  logic bus_idle;
  logic is_write;
  logic write_accept;
  logic read_accept;
  logic read_done;

  // No new request is taken in the ready cycle, the master still holds valid then
  assign bus_idle = !write_active && !read_pending && !uart_ready;
  assign is_write = |uart_wstrb;
  assign write_accept = uart_valid && bus_idle && is_write;
  assign read_accept = uart_valid && bus_idle && !is_write;

  // Frames with a bad stop bit leave the read waiting
  assign read_done = read_pending && rx_frame.valid && !rx_frame.frame_error;

  // Strobe goes out in the accepting cycle so the start bit follows the edge
  assign tx_request = '{start: write_accept, data: uart_wdata[7:0]};

  always_ff @(posedge clock) begin
    if (reset) begin
      write_active <= 1'b0;
    end else if (write_accept) begin
      write_active <= 1'b1;
    end else if (tx_done) begin
      write_active <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      read_pending <= 1'b0;
    end else if (read_accept) begin
      read_pending <= 1'b1;
    end else if (read_done) begin
      read_pending <= 1'b0;
    end
  end

  // One ready pulse from either completion
  always_ff @(posedge clock) begin
    if (reset) begin
      uart_ready <= 1'b0;
    end else begin
      uart_ready <= (write_active && tx_done) || read_done;
    end
  end

  // Read data holds until the next read completes
  always_ff @(posedge clock) begin
    if (reset) begin
      uart_rdata <= '0;
    end else if (read_done) begin
      uart_rdata <= uart_pkg::bus_word_t'(rx_frame.data);
    end
  end

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

  // Bit period kept short so simulation runs quickly
  localparam int cycles_per_bit = 16;
  localparam int half_bit = cycles_per_bit / 2;
  localparam int data_bits = 8;

  typedef logic [7:0] uart_byte_t;
  typedef logic [31:0] bus_word_t;
  typedef logic [3:0] byte_strobe_t;
  typedef logic [15:0] baud_count_t;
  typedef logic [3:0] bit_index_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  // Start is a single-cycle strobe, data is the byte to frame
  typedef struct packed {
    logic start;
    uart_byte_t data;
  } tx_request_t;

  // One pulse per completed frame, good or bad
  typedef struct packed {
    logic valid;
    uart_byte_t data;
    logic frame_error;
  } rx_frame_t;

endpackage

// File: logic/uart_receiver.sv
`timescale 1ns/100ps

module uart_receiver (
  input logic clock,
  input logic reset,
  input logic uart_rx,
  output uart_pkg::rx_frame_t rx_frame
);

  logic rx_meta;
  logic rx_sync;
  uart_pkg::rx_state_t state;
  uart_pkg::baud_count_t baud_count;
  uart_pkg::bit_index_t bit_index;
  uart_pkg::uart_byte_t shift_reg;
  logic half_end;
  logic bit_end;
  logic last_bit;
  logic frame_valid;
  logic frame_error;
  uart_pkg::uart_byte_t frame_data;

  // Two flops against metastability, idle level is high
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= uart_rx;
      rx_sync <= rx_meta;
    end
  end

  assign half_end = (baud_count == uart_pkg::baud_count_t'(uart_pkg::half_bit - 1));
  assign bit_end = (baud_count == uart_pkg::baud_count_t'(uart_pkg::cycles_per_bit - 1));
  assign last_bit = (bit_index == uart_pkg::bit_index_t'(uart_pkg::data_bits - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= uart_pkg::rx_idle;
      baud_count <= '0;
      bit_index <= '0;
      frame_valid <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      case (state)
        uart_pkg::rx_idle: begin
          baud_count <= '0;
          bit_index <= '0;
          if (!rx_sync) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          if (half_end) begin
            baud_count <= '0;
            // Line back high at mid-bit means a glitch
            if (rx_sync) begin
              state <= uart_pkg::rx_idle;
            end else begin
              state <= uart_pkg::rx_data;
            end
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        uart_pkg::rx_data: begin
          if (bit_end) begin
            baud_count <= '0;
            if (last_bit) begin
              state <= uart_pkg::rx_stop;
            end else begin
              bit_index <= bit_index + 1'b1;
            end
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        uart_pkg::rx_stop: begin
          if (bit_end) begin
            baud_count <= '0;
            frame_valid <= 1'b1;
            frame_error <= !rx_sync;
            state <= uart_pkg::rx_idle;
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::rx_idle;
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (state == uart_pkg::rx_data && bit_end) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (state == uart_pkg::rx_stop && bit_end) begin
      frame_data <= shift_reg;
    end
  end

  assign rx_frame = '{valid: frame_valid, data: frame_data, frame_error: frame_error};

endmodule

// File: logic/uart_transmitter.sv
`timescale 1ns/100ps

module uart_transmitter (
  input logic clock,
  input logic reset,
  input uart_pkg::tx_request_t tx_request,
  output logic uart_tx,
  output logic tx_done
);

  uart_pkg::tx_state_t state;
  uart_pkg::baud_count_t baud_count;
  uart_pkg::bit_index_t bit_index;
  uart_pkg::uart_byte_t shift_reg;
  logic bit_end;
  logic last_bit;

  assign bit_end = (baud_count == uart_pkg::baud_count_t'(uart_pkg::cycles_per_bit - 1));
  assign last_bit = (bit_index == uart_pkg::bit_index_t'(uart_pkg::data_bits - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= uart_pkg::tx_idle;
      baud_count <= '0;
      bit_index <= '0;
    end else begin
      case (state)
        uart_pkg::tx_idle: begin
          baud_count <= '0;
          bit_index <= '0;
          if (tx_request.start) begin
            state <= uart_pkg::tx_start;
          end
        end
        uart_pkg::tx_start: begin
          if (bit_end) begin
            baud_count <= '0;
            bit_index <= '0;
            state <= uart_pkg::tx_data;
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        uart_pkg::tx_data: begin
          if (bit_end) begin
            baud_count <= '0;
            if (last_bit) begin
              state <= uart_pkg::tx_stop;
            end else begin
              bit_index <= bit_index + 1'b1;
            end
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        uart_pkg::tx_stop: begin
          if (bit_end) begin
            baud_count <= '0;
            state <= uart_pkg::tx_idle;
          end else begin
            baud_count <= baud_count + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::tx_idle;
        end
      endcase
    end
  end

  // Byte is loaded on the start strobe and shifted out LSB first
  always_ff @(posedge clock) begin
    if (state == uart_pkg::tx_idle && tx_request.start) begin
      shift_reg <= tx_request.data;
    end else if (state == uart_pkg::tx_data && bit_end) begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

  always_comb begin
    case (state)
      uart_pkg::tx_start: uart_tx = 1'b0;
      uart_pkg::tx_data: uart_tx = shift_reg[0];
      default: uart_tx = 1'b1;
    endcase
  end

  // Last cycle of the stop bit
  assign tx_done = (state == uart_pkg::tx_stop) && bit_end;

endmodule

// File: verilog.f
logic/uart_pkg.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_bus_port.sv
logic/uart.sv
dv/uart_properties.sv
dv/uart_tb.sv
